//--- hw/bam_pkg.sv
//------------------------------
// avalon-mm master bridge package
// shared widths, constants and bundle types
//------------------------------

package bam_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int BAM_DATA_W     = 64;
  localparam int BAM_BE_W       = BAM_DATA_W / 8;
  localparam int BAM_ADDR_W     = 32;
  localparam int BAM_BURST_W    = 4;
  // one data word is 8 bytes
  localparam int BAM_ALIGN_BITS = 3;

  // ------------------------------
  // constants
  // ------------------------------
  // returned for reads that fall outside the window
  localparam logic [BAM_DATA_W-1:0] BAM_POISON_WORD = {2{32'hDEAD_0ADD}};
  // free completion entries required before a command may start
  localparam int BAM_CREDIT_MARGIN = 16;

  // ------------------------------
  // types
  // ------------------------------
  typedef enum logic [1:0] {
    IDLE,
    POP_CMD,
    WR,
    RD
  } bam_state_e;

  // one entry of the command fifo
  typedef struct packed {
    logic                   is_wr;
    logic [BAM_ADDR_W-1:0]  addr;
    logic [BAM_BURST_W-1:0] burst;
    logic [BAM_BE_W-1:0]    rd_be;
  } bam_cmd_t;

  // one entry of the write data fifo
  typedef struct packed {
    logic [BAM_DATA_W-1:0] data;
    logic [BAM_BE_W-1:0]   be;
  } bam_wdata_t;

  // sequencer output, one per cycle
  typedef struct packed {
    logic       wr_beat;
    logic       rd_go;
    bam_cmd_t   cmd;
    bam_wdata_t wdata;
  } bam_beat_t;

  typedef struct packed {
    logic                   write;
    logic                   read;
    logic [BAM_ADDR_W-1:0]  addr;
    logic [BAM_BURST_W-1:0] burst;
    logic [BAM_DATA_W-1:0]  wdata;
    logic [BAM_BE_W-1:0]    be;
  } bam_req_t;

  typedef struct packed {
    logic                  err;
    logic [BAM_DATA_W-1:0] data;
  } bam_cpl_t;

endpackage

//--- hw/bam_cmd_sequencer.sv
//------------------------------
// command sequencer
// pops command and write data fifos, one beat per cycle
//------------------------------

`timescale 1ns/1ns

module bam_cmd_sequencer
  import bam_pkg::*;
(
  input  logic       clk,
  input  logic       srst_reg,
  input  bam_cmd_t   cmd_i,
  input  logic       cmd_empty_i,
  input  logic       waitrequest_i,
  input  logic       credit_ok_i,
  input  logic       issuer_busy_i,
  output logic       cmd_pop_o,
  output logic       wdata_pop_o,
  output bam_beat_t  beat_o,
  input  bam_wdata_t wdata_i
);

  bam_state_e             state_q;
  bam_state_e             state_d;
  logic                   cmd_avail_q;
  logic                   wait_req_q;
  logic                   start_ok;
  bam_cmd_t               cmd_q;
  logic [BAM_BURST_W-1:0] beat_cnt_q;

  // start conditions are sampled one cycle ahead
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      cmd_avail_q <= 1'b0;
      wait_req_q  <= 1'b0;
    end else begin
      cmd_avail_q <= ~cmd_empty_i;
      wait_req_q  <= waitrequest_i;
    end
  end

  assign start_ok = cmd_avail_q & ~wait_req_q & credit_ok_i & ~issuer_busy_i;

  // ------------------------------
  // state machine
  // ------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_ok) begin
          state_d = POP_CMD;
        end
      end
      // fifo head is valid here, decide on it directly
      POP_CMD: state_d = cmd_i.is_wr ? WR : RD;
      WR: begin
        if (beat_cnt_q == BAM_BURST_W'(1)) begin
          state_d = IDLE;
        end
      end
      RD:      state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // latch command and load write beat counter
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      beat_cnt_q <= '0;
    end else if (state_q == POP_CMD) begin
      beat_cnt_q <= cmd_i.burst;
    end else if (state_q == WR) begin
      beat_cnt_q <= beat_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == POP_CMD) begin
      cmd_q <= cmd_i;
    end
  end

  assign cmd_pop_o      = (state_q == POP_CMD);
  assign wdata_pop_o    = (state_q == WR);
  assign beat_o.wr_beat = (state_q == WR);
  assign beat_o.rd_go   = (state_q == RD);
  assign beat_o.cmd     = cmd_q;
  assign beat_o.wdata   = wdata_i;

endmodule

//--- hw/bam_burst_issuer.sv
//------------------------------
// burst issuer
// registers avalon requests, checks the address window
// and merges read returns with poison beats
//------------------------------

`timescale 1ns/1ns

module bam_burst_issuer
  import bam_pkg::*;
#(
  parameter int WIN_BITS = 15
) (
  input  logic                   clk,
  input  logic                   srst_reg,
  input  bam_beat_t              beat_i,
  input  logic [BAM_DATA_W-1:0]  readdata_i,
  input  logic                   readdatavalid_i,
  input  logic [1:0]             response_i,
  output bam_req_t               req_o,
  output logic                   cpl_wr_valid_o,
  output bam_cpl_t               cpl_wr_data_o,
  output logic                   rd_issue_o,
  output logic [BAM_BURST_W-1:0] rd_burst_o,
  output logic                   busy_o
);

  // wide enough for every read beat the credit check lets through
  localparam int RD_CNT_W = 12;

  logic                   out_of_range;
  logic [BAM_ADDR_W-1:0]  addr_aligned;
  logic [RD_CNT_W-1:0]    rd_pend_q;
  logic [RD_CNT_W-1:0]    rd_add;
  logic [BAM_BURST_W-1:0] poison_cnt_q;
  logic                   poison_go;
  logic                   poison_wr_q;

  // any address bit at or above the window size is out of range
  assign out_of_range = |beat_i.cmd.addr[BAM_ADDR_W-1:WIN_BITS];
  assign addr_aligned = {beat_i.cmd.addr[BAM_ADDR_W-1:BAM_ALIGN_BITS],
                         {BAM_ALIGN_BITS{1'b0}}};

  // ------------------------------
  // request register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      req_o.write <= 1'b0;
      req_o.read  <= 1'b0;
    end else begin
      req_o.write <= beat_i.wr_beat & ~out_of_range;
      req_o.read  <= beat_i.rd_go & ~out_of_range;
    end
    req_o.addr  <= addr_aligned;
    req_o.burst <= beat_i.cmd.burst;
    req_o.wdata <= beat_i.wdata.data;
    if (beat_i.rd_go) begin
      req_o.be <= beat_i.cmd.rd_be;
    end else if (out_of_range) begin
      req_o.be <= '0;
    end else begin
      req_o.be <= beat_i.wdata.be;
    end
  end

  // every read goes to the credit monitor, issued or not
  assign rd_issue_o = beat_i.rd_go;
  assign rd_burst_o = beat_i.cmd.burst;

  // ------------------------------
  // outstanding bus reads
  // ------------------------------
  assign rd_add = (beat_i.rd_go && !out_of_range) ? RD_CNT_W'(beat_i.cmd.burst) : '0;

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      rd_pend_q <= '0;
    end else begin
      rd_pend_q <= rd_pend_q + rd_add - RD_CNT_W'(readdatavalid_i);
    end
  end

  // poison beats go out only once the bus has drained, keeping order
  assign poison_go = (poison_cnt_q != '0) && (rd_pend_q == '0) && !readdatavalid_i;

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      poison_cnt_q <= '0;
    end else if (beat_i.rd_go && out_of_range) begin
      poison_cnt_q <= beat_i.cmd.burst;
    end else if (poison_go) begin
      poison_cnt_q <= poison_cnt_q - 1'b1;
    end
  end

  // ------------------------------
  // completion stage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      cpl_wr_valid_o <= 1'b0;
      poison_wr_q    <= 1'b0;
    end else begin
      cpl_wr_valid_o <= readdatavalid_i | poison_go;
      poison_wr_q    <= poison_go;
    end
    if (readdatavalid_i) begin
      cpl_wr_data_o.err  <= |response_i;
      cpl_wr_data_o.data <= readdata_i;
    end else begin
      cpl_wr_data_o.err  <= 1'b0;
      cpl_wr_data_o.data <= BAM_POISON_WORD;
    end
  end

  assign busy_o = (poison_cnt_q != '0) | poison_wr_q;

endmodule

//--- hw/bam_cpl_buffer.sv
//------------------------------
// completion buffer
// read return memory with pointers and credit monitor
//------------------------------

`timescale 1ns/1ns

module bam_cpl_buffer
  import bam_pkg::*;
#(
  parameter int CPL_AW = 9
) (
  input  logic                   clk,
  input  logic                   srst_reg,
  input  logic                   wr_valid_i,
  input  bam_cpl_t               wr_data_i,
  input  logic                   rd_issue_i,
  input  logic [BAM_BURST_W-1:0] rd_burst_i,
  input  logic                   pop_i,
  output bam_cpl_t               cpl_o,
  output logic                   cpl_valid_o,
  output logic                   credit_ok_o
);

  localparam int DEPTH = 2 ** CPL_AW;
  // highest count at which a new command may still start
  localparam logic [CPL_AW:0] CREDIT_LIMIT = (CPL_AW + 1)'(DEPTH - BAM_CREDIT_MARGIN);

  bam_cpl_t          mem [DEPTH];
  logic [CPL_AW-1:0] wr_ptr_q;
  logic [CPL_AW-1:0] rd_ptr_q;
  logic [CPL_AW:0]   credit_q;
  logic [CPL_AW:0]   credit_add;
  logic [CPL_AW:0]   credit_sub;

  // ------------------------------
  // memory
  // ------------------------------
  // simple dual port memory with one write and one registered read
  always_ff @(posedge clk) begin
    if (wr_valid_i) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // popped entry shows up on the next cycle
  always_ff @(posedge clk) begin
    if (pop_i) begin
      cpl_o <= mem[rd_ptr_q];
    end
  end

  // ------------------------------
  // pointers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      wr_ptr_q <= '0;
    end else if (wr_valid_i) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      rd_ptr_q <= '0;
    end else if (pop_i) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // consumer counts these pulses to know what is available
  assign cpl_valid_o = wr_valid_i;

  // ------------------------------
  // credit monitor
  // ------------------------------
  // whole burst is reserved at issue and released one entry per pop
  assign credit_add = rd_issue_i ? (CPL_AW + 1)'(rd_burst_i) : '0;
  assign credit_sub = (CPL_AW + 1)'(pop_i);

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_q + credit_add - credit_sub;
    end
  end

  // the margin leaves room for one more full burst
  assign credit_ok_o = (credit_q <= CREDIT_LIMIT);

endmodule

//--- hw/bam_avmm_master.sv
//------------------------------
// bar to avalon-mm master bridge top level
// sequencer, issuer and completion buffer
//------------------------------

`timescale 1ns/1ns

module bam_avmm_master
  import bam_pkg::*;
#(
  parameter int WIN_BITS = 15,
  parameter int CPL_AW   = 9
) (
  input  logic                  clk,
  input  logic                  srst_reg,
  // command fifo
  input  bam_cmd_t              cmd_i,
  input  logic                  cmd_empty_i,
  output logic                  cmd_pop_o,
  // write data fifo
  input  bam_wdata_t            wdata_i,
  output logic                  wdata_pop_o,
  // avalon-mm master
  output bam_req_t              avm_req_o,
  input  logic                  avm_waitrequest_i,
  input  logic [BAM_DATA_W-1:0] avm_readdata_i,
  input  logic                  avm_readdatavalid_i,
  input  logic [1:0]            avm_response_i,
  // completion output
  input  logic                  cpl_pop_i,
  output bam_cpl_t              cpl_o,
  output logic                  cpl_valid_o
);

  bam_beat_t              seq_beat;
  logic                   issuer_busy;
  logic                   cpl_wr_valid;
  bam_cpl_t               cpl_wr_data;
  logic                   rd_issue;
  logic [BAM_BURST_W-1:0] rd_burst;
  logic                   credit_ok;

  bam_cmd_sequencer i_seq (
    .clk           (clk),
    .srst_reg      (srst_reg),
    .cmd_i         (cmd_i),
    .cmd_empty_i   (cmd_empty_i),
    .waitrequest_i (avm_waitrequest_i),
    .credit_ok_i   (credit_ok),
    .issuer_busy_i (issuer_busy),
    .cmd_pop_o     (cmd_pop_o),
    .wdata_pop_o   (wdata_pop_o),
    .beat_o        (seq_beat),
    .wdata_i       (wdata_i)
  );

  bam_burst_issuer #(
    .WIN_BITS (WIN_BITS)
  ) i_issuer (
    .clk             (clk),
    .srst_reg        (srst_reg),
    .beat_i          (seq_beat),
    .readdata_i      (avm_readdata_i),
    .readdatavalid_i (avm_readdatavalid_i),
    .response_i      (avm_response_i),
    .req_o           (avm_req_o),
    .cpl_wr_valid_o  (cpl_wr_valid),
    .cpl_wr_data_o   (cpl_wr_data),
    .rd_issue_o      (rd_issue),
    .rd_burst_o      (rd_burst),
    .busy_o          (issuer_busy)
  );

  bam_cpl_buffer #(
    .CPL_AW (CPL_AW)
  ) i_cpl_buf (
    .clk         (clk),
    .srst_reg    (srst_reg),
    .wr_valid_i  (cpl_wr_valid),
    .wr_data_i   (cpl_wr_data),
    .rd_issue_i  (rd_issue),
    .rd_burst_i  (rd_burst),
    .pop_i       (cpl_pop_i),
    .cpl_o       (cpl_o),
    .cpl_valid_o (cpl_valid_o),
    .credit_ok_o (credit_ok)
  );

endmodule

//--- test/tb_clock_gen.sv
//------------------------------
// testbench clock and reset
// 20 ns clock, reset held for 2 cycles
//------------------------------

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic srst_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    srst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    srst_o <= 1'b0;
  end

endmodule

//--- test/bam_tb_slave.sv
//------------------------------
// avalon-mm slave model
// word memory, random waitrequest between bursts
// and a fixed read latency
//------------------------------

`timescale 1ns/1ns

module bam_tb_slave
  import bam_pkg::*;
#(
  parameter int WORDS  = 4096,
  parameter int RD_LAT = 4
) (
  input  logic                  clk,
  input  logic                  srst_reg,
  input  bam_req_t              req_i,
  output logic                  waitrequest_o,
  output logic [BAM_DATA_W-1:0] readdata_o,
  output logic                  readdatavalid_o,
  output logic [1:0]            response_o
);

  logic [BAM_DATA_W-1:0] mem [WORDS];
  logic [BAM_DATA_W-1:0] ret_data_q [$];
  logic [1:0]            ret_resp_q [$];
  int unsigned           ret_time_q [$];
  int unsigned           cyc;
  int unsigned           next_slot;
  int unsigned           slot;
  int unsigned           word;
  int unsigned           wr_word;
  int unsigned           wr_left;

  // outputs idle before the first clock edge
  initial begin
    waitrequest_o   = 1'b0;
    readdatavalid_o = 1'b0;
    readdata_o      = '0;
    response_o      = 2'b00;
  end

  // fill pattern covers the whole word index
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {32'(i) * 32'h9E37_79B9, ~32'(i)};
    end
  end

  // slave error for any beat whose byte address has bit 14 set
  function automatic logic [1:0] beat_resp(int unsigned w);
    logic [BAM_ADDR_W-1:0] byte_addr;
    byte_addr = 32'(w) << BAM_ALIGN_BITS;
    return byte_addr[14] ? 2'b10 : 2'b00;
  endfunction

  always @(posedge clk) begin
    if (srst_reg) begin
      waitrequest_o   <= 1'b0;
      readdatavalid_o <= 1'b0;
      readdata_o      <= '0;
      response_o      <= 2'b00;
      cyc       = 0;
      next_slot = 0;
      wr_left   = 0;
      ret_data_q.delete();
      ret_resp_q.delete();
      ret_time_q.delete();
    end else begin
      cyc = cyc + 1;
      // burst address is taken from the first beat only
      if (req_i.write) begin
        if (wr_left == 0) begin
          wr_word = req_i.addr[14:BAM_ALIGN_BITS];
          wr_left = req_i.burst;
        end
        for (int b = 0; b < BAM_BE_W; b++) begin
          if (req_i.be[b]) begin
            mem[wr_word][8*b +: 8] = req_i.wdata[8*b +: 8];
          end
        end
        wr_word = wr_word + 1;
        wr_left = wr_left - 1;
      end
      // read data captured at the request, returned back to back
      if (req_i.read) begin
        slot = (cyc + RD_LAT > next_slot) ? cyc + RD_LAT : next_slot;
        word = req_i.addr[14:BAM_ALIGN_BITS];
        for (int k = 0; k < req_i.burst; k++) begin
          ret_data_q.push_back(mem[word + k]);
          ret_resp_q.push_back(beat_resp(word + k));
          ret_time_q.push_back(slot + k);
        end
        next_slot = slot + req_i.burst;
      end
      if (ret_time_q.size() != 0 && ret_time_q[0] == cyc) begin
        readdatavalid_o <= 1'b1;
        readdata_o      <= ret_data_q[0];
        response_o      <= ret_resp_q[0];
        ret_data_q.delete(0);
        ret_resp_q.delete(0);
        ret_time_q.delete(0);
      end else begin
        readdatavalid_o <= 1'b0;
      end
      // only between write bursts
      waitrequest_o <= (wr_left == 0) && ($urandom_range(0, 3) == 0);
    end
  end

endmodule

//--- test/bam_tb.sv
//------------------------------
// bridge testbench
// random commands against a memory model, checks bus
// strobes, completions and final memory contents
//------------------------------

`timescale 1ns/1ns

module bam_tb
  import bam_pkg::*;
();

  localparam int NUM_CMDS = 200;
  localparam int WORDS    = 4096;
  localparam int CPL_AW   = 5;
  localparam int DEPTH    = 2 ** CPL_AW;
  localparam int TIMEOUT  = 100000;
  localparam int K_REQ    = 0;
  localparam int K_CPL    = 1;
  localparam int K_MEM    = 2;
  localparam int K_MISC   = 3;

  logic                  clk;
  logic                  srst_reg;
  bam_cmd_t              cmd;
  logic                  cmd_empty;
  logic                  cmd_pop;
  bam_wdata_t            wdata;
  logic                  wdata_pop;
  bam_req_t              avm_req;
  logic                  avm_waitrequest;
  logic [BAM_DATA_W-1:0] avm_readdata;
  logic                  avm_readdatavalid;
  logic [1:0]            avm_response;
  logic                  cpl_pop;
  bam_cpl_t              cpl;
  logic                  cpl_valid;

  bam_cmd_t              cmd_fifo [$];
  bam_wdata_t            wdata_fifo [$];
  bam_req_t              exp_wr_q [$];
  bam_req_t              exp_rd_q [$];
  bam_cpl_t              exp_cpl_q [$];
  logic [BAM_DATA_W-1:0] model_mem [WORDS];
  int                    err_cnt [4];
  int unsigned           avail;
  int unsigned           pause;
  int unsigned           rd_out;
  logic                  check_next;
  int unsigned           seed;
  int unsigned           wait_cycles;

  tb_clock_gen i_clk (
    .clk_o  (clk),
    .srst_o (srst_reg)
  );

  bam_tb_slave #(
    .WORDS (WORDS)
  ) i_slave (
    .clk             (clk),
    .srst_reg        (srst_reg),
    .req_i           (avm_req),
    .waitrequest_o   (avm_waitrequest),
    .readdata_o      (avm_readdata),
    .readdatavalid_o (avm_readdatavalid),
    .response_o      (avm_response)
  );

  bam_avmm_master #(
    .WIN_BITS (15),
    .CPL_AW   (CPL_AW)
  ) i_dut (
    .clk                 (clk),
    .srst_reg            (srst_reg),
    .cmd_i               (cmd),
    .cmd_empty_i         (cmd_empty),
    .cmd_pop_o           (cmd_pop),
    .wdata_i             (wdata),
    .wdata_pop_o         (wdata_pop),
    .avm_req_o           (avm_req),
    .avm_waitrequest_i   (avm_waitrequest),
    .avm_readdata_i      (avm_readdata),
    .avm_readdatavalid_i (avm_readdatavalid),
    .avm_response_i      (avm_response),
    .cpl_pop_i           (cpl_pop),
    .cpl_o               (cpl),
    .cpl_valid_o         (cpl_valid)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_value(input string test, input logic [63:0] want,
                             input logic [63:0] got, input int kind);
    assert (got === want) else begin
      err_cnt[kind]++;
      $display("error %s: expected %h actual %h", test, want, got);
    end
  endtask

  // bit 14 of the beat's byte address selects an error response
  function automatic logic addr_err(int unsigned word);
    logic [BAM_ADDR_W-1:0] byte_addr;
    byte_addr = 32'(word) << BAM_ALIGN_BITS;
    return byte_addr[14];
  endfunction

  task automatic model_write(input int unsigned word, input bam_wdata_t w);
    for (int b = 0; b < BAM_BE_W; b++) begin
      if (w.be[b]) begin
        model_mem[word][8*b +: 8] = w.data[8*b +: 8];
      end
    end
  endtask

  // builds the fifo contents and every expected strobe and completion
  task automatic gen_commands();
    bam_cmd_t    c;
    bam_wdata_t  w;
    bam_req_t    r;
    bam_cpl_t    e;
    logic        oor;
    int unsigned idx;
    int unsigned bit_pos;
    for (int n = 0; n < NUM_CMDS; n++) begin
      c.is_wr = 1'($urandom_range(0, 1));
      c.burst = 4'($urandom_range(1, 15));
      c.rd_be = 8'($urandom);
      idx     = $urandom_range(0, WORDS - 16);
      oor     = ($urandom_range(0, 7) == 0);
      c.addr  = {17'd0, 12'(idx), 3'($urandom)};
      if (oor) begin
        bit_pos         = $urandom_range(15, 31);
        c.addr[bit_pos] = 1'b1;
      end
      cmd_fifo.push_back(c);
      r       = '0;
      r.addr  = {c.addr[BAM_ADDR_W-1:BAM_ALIGN_BITS], {BAM_ALIGN_BITS{1'b0}}};
      r.burst = c.burst;
      if (!oor && !c.is_wr) begin
        r.read = 1'b1;
        r.be   = c.rd_be;
        exp_rd_q.push_back(r);
      end
      for (int k = 0; k < c.burst; k++) begin
        if (c.is_wr) begin
          w.data = {$urandom, $urandom};
          w.be   = 8'($urandom);
          wdata_fifo.push_back(w);
          if (!oor) begin
            r.write = 1'b1;
            r.wdata = w.data;
            r.be    = w.be;
            exp_wr_q.push_back(r);
            model_write(idx + k, w);
          end
        end else begin
          if (oor) begin
            e.err  = 1'b0;
            e.data = BAM_POISON_WORD;
          end else begin
            e.err  = addr_err(idx + k);
            e.data = model_mem[idx + k];
          end
          exp_cpl_q.push_back(e);
        end
      end
    end
  endtask

  function automatic logic all_done();
    return (cmd_fifo.size() == 0) && (exp_wr_q.size() == 0) &&
           (exp_rd_q.size() == 0) && (exp_cpl_q.size() == 0) && !check_next;
  endfunction

  task automatic finish_run();
    $display("errors: request %0d, completion %0d, memory %0d, other %0d",
             err_cnt[K_REQ], err_cnt[K_CPL], err_cnt[K_MEM], err_cnt[K_MISC]);
    if (err_cnt[K_REQ] + err_cnt[K_CPL] + err_cnt[K_MEM] + err_cnt[K_MISC] == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // ------------------------------
  // show-ahead fifo models
  // ------------------------------
  always @(posedge clk) begin : fifo_model
    if (!srst_reg) begin
      if (cmd_pop) begin
        assert (cmd_fifo.size() != 0) else begin
          err_cnt[K_MISC]++;
          $display("command fifo popped while empty");
        end
        if (cmd_fifo.size() != 0) begin
          cmd_fifo.delete(0);
        end
      end
      if (wdata_pop) begin
        assert (wdata_fifo.size() != 0) else begin
          err_cnt[K_MISC]++;
          $display("write data fifo popped while empty");
        end
        if (wdata_fifo.size() != 0) begin
          wdata_fifo.delete(0);
        end
      end
    end
    cmd_empty <= srst_reg || (cmd_fifo.size() == 0);
    cmd       <= (cmd_fifo.size() != 0) ? cmd_fifo[0] : '0;
    wdata     <= (wdata_fifo.size() != 0) ? wdata_fifo[0] : '0;
  end

  // ------------------------------
  // bus request monitor
  // ------------------------------
  always @(posedge clk) begin : req_monitor
    bam_req_t want;
    if (!srst_reg && (avm_req.write || avm_req.read)) begin
      assert (avm_req.addr[BAM_ADDR_W-1:15] == '0) else begin
        err_cnt[K_REQ]++;
        $display("bus strobe raised for address %h outside the window", avm_req.addr);
      end
    end
    if (!srst_reg && avm_req.write) begin
      assert (exp_wr_q.size() != 0) else begin
        err_cnt[K_REQ]++;
        $display("write strobe at address %h with no write expected", avm_req.addr);
      end
      if (exp_wr_q.size() != 0) begin
        want = exp_wr_q.pop_front();
        check_value("wr_req addr", want.addr, avm_req.addr, K_REQ);
        check_value("wr_req burst", want.burst, avm_req.burst, K_REQ);
        check_value("wr_req data", want.wdata, avm_req.wdata, K_REQ);
        check_value("wr_req be", want.be, avm_req.be, K_REQ);
      end
    end
    if (!srst_reg && avm_req.read) begin
      assert (exp_rd_q.size() != 0) else begin
        err_cnt[K_REQ]++;
        $display("read strobe at address %h with no read expected", avm_req.addr);
      end
      if (exp_rd_q.size() != 0) begin
        want = exp_rd_q.pop_front();
        check_value("rd_req addr", want.addr, avm_req.addr, K_REQ);
        check_value("rd_req burst", want.burst, avm_req.burst, K_REQ);
        check_value("rd_req be", want.be, avm_req.be, K_REQ);
      end
    end
  end

  // ------------------------------
  // completion consumer and credit check
  // ------------------------------
  always @(posedge clk) begin : consumer
    bam_cpl_t want;
    if (srst_reg) begin
      cpl_pop    <= 1'b0;
      check_next = 1'b0;
      avail      = 0;
      rd_out     = 0;
      // long hold at the start so the credit limit is reached
      pause      = 600;
    end else begin
      if (check_next) begin
        assert (exp_cpl_q.size() != 0) else begin
          err_cnt[K_CPL]++;
          $display("completion popped with none expected");
        end
        if (exp_cpl_q.size() != 0) begin
          want = exp_cpl_q.pop_front();
          check_value("cpl err", want.err, cpl.err, K_CPL);
          check_value("cpl data", want.data, cpl.data, K_CPL);
        end
      end
      check_next = cpl_pop;
      avail      = avail + cpl_valid - cpl_pop;
      if (cmd_pop && !cmd.is_wr) begin
        rd_out = rd_out + cmd.burst;
      end
      rd_out = rd_out - cpl_pop;
      assert (rd_out <= DEPTH) else begin
        err_cnt[K_CPL]++;
        $display("credit: %0d read beats outstanding, more than the buffer holds", rd_out);
      end
      if (pause != 0) begin
        pause--;
      end else if ($urandom_range(0, 63) == 0) begin
        pause = $urandom_range(100, 400);
      end
      cpl_pop <= (pause == 0) && (avail != 0) && ($urandom_range(0, 1) == 1);
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    seed = 35996;
    void'($urandom(seed));
    cmd_empty = 1'b1;
    cmd       = '0;
    wdata     = '0;
    cpl_pop   = 1'b0;
    for (int i = 0; i < 4; i++) begin
      err_cnt[i] = 0;
    end
    for (int i = 0; i < WORDS; i++) begin
      model_mem[i] = {32'(i) * 32'h9E37_79B9, ~32'(i)};
    end
    gen_commands();

    wait_cycles = 0;
    while (srst_reg !== 1'b0 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    assert (srst_reg === 1'b0) else begin
      err_cnt[K_MISC]++;
      $display("reset was never released");
    end
    // pops and strobes held low out of reset
    check_value("reset outputs", 64'd0,
                {cmd_pop, wdata_pop, avm_req.write, avm_req.read, cpl_valid}, K_MISC);

    wait_cycles = 0;
    while (!all_done() && wait_cycles < TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    assert (all_done()) else begin
      err_cnt[K_MISC]++;
      $display("timeout: %0d commands and %0d completions still pending",
               cmd_fifo.size(), exp_cpl_q.size());
    end
    if (all_done()) begin
      // last write beat lands in the slave on this edge
      @(posedge clk);
      for (int i = 0; i < WORDS; i++) begin
        check_value($sformatf("memory word %0d", i), model_mem[i], i_slave.mem[i], K_MEM);
      end
    end
    finish_run();
  end

endmodule

//--- tb.f
hw/bam_pkg.sv
hw/bam_cmd_sequencer.sv
hw/bam_burst_issuer.sv
hw/bam_cpl_buffer.sv
hw/bam_avmm_master.sv
test/tb_clock_gen.sv
test/bam_tb_slave.sv
test/bam_tb.sv
